// ==== shifter_pkg.sv ====
// ====================
// Shared by RTL and testbench
// Counters wrap silently at 2^COUNT_WIDTH
// ====================
package shifter_pkg;

    // Operation code carried alongside each operand
    typedef logic [1:0] shift_op_t;

    // Shift left, zeros enter at the bottom
    localparam shift_op_t OP_LEFT        = 2'd0;

    // Shift right, zeros enter at the top
    localparam shift_op_t OP_RIGHT_LOGIC = 2'd1;

    // Shift right, sign bit replicated at the top
    localparam shift_op_t OP_RIGHT_ARITH = 2'd2;

    // Rotate right, bits leaving the bottom re-enter at the top
    localparam shift_op_t OP_ROTATE      = 2'd3;

    // Width of the per-class operation counters
    localparam int COUNT_WIDTH = 16;

    // Wrapping operation count
    typedef logic [COUNT_WIDTH-1:0] count_t;

endpackage

// ==== barrel_shift_core.sv ====
// ====================
// Pure combinational, DATA_WIDTH a power of two and at least 2
// ====================
module barrel_shift_core #(
    parameter int DATA_WIDTH = 32
) (
    input  logic [DATA_WIDTH-1:0]         operand,
    input  logic [$clog2(DATA_WIDTH)-1:0] amount,
    input  shifter_pkg::shift_op_t        op,
    output logic [DATA_WIDTH-1:0]         result
);

    localparam int AMT_WIDTH = $clog2(DATA_WIDTH);

    typedef logic [DATA_WIDTH-1:0] word_t;

    logic  left_en;
    logic  rotate_en;
    logic  fill_bit;
    word_t pre_value;
    word_t stage_value [AMT_WIDTH+1];

    // Mirror bit order so one right shifter also serves left shifts
    function automatic word_t reverse_bits(input word_t value);
        word_t reversed;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            reversed[i] = value[DATA_WIDTH-1-i];
        end
        return reversed;
    endfunction

    assign left_en   = (op == shifter_pkg::OP_LEFT);
    assign rotate_en = (op == shifter_pkg::OP_ROTATE);

    // Sign extension only for the arithmetic right shift
    assign fill_bit = (op == shifter_pkg::OP_RIGHT_ARITH) ? operand[DATA_WIDTH-1] : 1'b0;

    assign pre_value      = left_en ? reverse_bits(operand) : operand;
    assign stage_value[0] = pre_value;

    // One mux level per amount bit, step doubles each level
    generate
        for (genvar i = 0; i < AMT_WIDTH; i++) begin : g_stage
            localparam int STEP = 2 ** i;

            word_t moved;

            always_comb begin
                if (rotate_en) begin
                    // Bits falling off the bottom wrap to the top
                    moved = {stage_value[i][STEP-1:0], stage_value[i][DATA_WIDTH-1:STEP]};
                end else begin
                    moved = {{STEP{fill_bit}}, stage_value[i][DATA_WIDTH-1:STEP]};
                end
            end

            assign stage_value[i+1] = amount[i] ? moved : stage_value[i];
        end
    endgenerate

    // Undo the mirror for left shifts
    assign result = left_en ? reverse_bits(stage_value[AMT_WIDTH])
                            : stage_value[AMT_WIDTH];

    // No amount bit set means every stage passes through, for every op
    always_comb begin
        if (amount == '0) begin
            assert (result == operand)
                else $error("barrel_shift_core: zero amount altered operand");
        end
    end

endmodule

// ==== shift_overflow_check.sv ====
// ====================
// Left shifts only, DATA_WIDTH a power of two
// ====================
module shift_overflow_check #(
    parameter int DATA_WIDTH = 32
) (
    input  logic [DATA_WIDTH-1:0]         operand,
    input  logic [$clog2(DATA_WIDTH)-1:0] amount,
    input  shifter_pkg::shift_op_t        op,
    output logic                          overflow
);

    typedef logic [DATA_WIDTH-1:0] word_t;

    localparam word_t ALL_ONES = {DATA_WIDTH{1'b1}};

    word_t keep_mask;
    word_t drop_mask;
    logic  is_left;
    logic  bits_lost;

    assign is_left = (op == shifter_pkg::OP_LEFT);

    // Low bits that survive the shift
    assign keep_mask = ALL_ONES >> amount;

    // Top amount bits are pushed out, empty for a zero amount
    assign drop_mask = ~keep_mask;

    assign bits_lost = |(operand & drop_mask);

    // Right shifts and rotates never lose information in this sense
    assign overflow = is_left & bits_lost;

endmodule

// ==== shift_op_counters.sv ====
// ====================
// Counts accepted operations per class, wraps at 2^16
// ====================
module shift_op_counters (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   shift_enable,
    input  shifter_pkg::shift_op_t shift_type,
    output shifter_pkg::count_t    left_count,
    output shifter_pkg::count_t    right_count,
    output shifter_pkg::count_t    rotate_count
);

    shifter_pkg::count_t total_count;

    // One class per accepted operation, both right kinds share a counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left_count   <= '0;
            right_count  <= '0;
            rotate_count <= '0;
        end else if (shift_enable) begin
            case (shift_type)
                shifter_pkg::OP_LEFT: begin
                    left_count <= left_count + 1'b1;
                end
                shifter_pkg::OP_RIGHT_LOGIC,
                shifter_pkg::OP_RIGHT_ARITH: begin
                    right_count <= right_count + 1'b1;
                end
                shifter_pkg::OP_ROTATE: begin
                    rotate_count <= rotate_count + 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // Modular sum, so wrap of any single counter is harmless
    assign total_count = left_count + right_count + rotate_count;

    // At most one operation accepted per edge
    a_single_increment: assert property (
        @(posedge clk) disable iff (rst)
        shifter_pkg::count_t'(total_count - $past(total_count)) <= shifter_pkg::count_t'(1)
    ) else $error("shift_op_counters: counter sum grew by more than one");

endmodule

// ==== shifter_top.sv ====
// ====================
// Result two edges after issue, no back-pressure
// DATA_WIDTH must be a power of two
// ====================
module shifter_top #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [DATA_WIDTH-1:0]         data_in,
    input  logic [$clog2(DATA_WIDTH)-1:0] shift_amount,
    input  shifter_pkg::shift_op_t        shift_type,
    input  logic                          shift_enable,
    output logic [DATA_WIDTH-1:0]         data_out,
    output logic                          shift_valid,
    output logic                          shift_overflow,
    output shifter_pkg::count_t           left_count,
    output shifter_pkg::count_t           right_count,
    output shifter_pkg::count_t           rotate_count
);

    localparam int AMT_WIDTH = $clog2(DATA_WIDTH);

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [AMT_WIDTH-1:0]  amount_t;

    // Stage A fields
    word_t                  a_data;
    amount_t                a_amount;
    shifter_pkg::shift_op_t a_op;
    logic                   a_valid;

    // Combinational outputs of stage A
    word_t core_result;
    logic  core_overflow;

    // Valid follows the strobe every edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_valid <= 1'b0;
        end else begin
            a_valid <= shift_enable;
        end
    end

    // Operand capture, only meaningful while a_valid is high
    always_ff @(posedge clk) begin
        if (shift_enable) begin
            a_data   <= data_in;
            a_amount <= shift_amount;
            a_op     <= shift_type;
        end
    end

    barrel_shift_core #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_core (
        .operand (a_data),
        .amount  (a_amount),
        .op      (a_op),
        .result  (core_result)
    );

    shift_overflow_check #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_ovf (
        .operand  (a_data),
        .amount   (a_amount),
        .op       (a_op),
        .overflow (core_overflow)
    );

    // Stage B holds the last result between pulses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_out       <= '0;
            shift_overflow <= 1'b0;
            shift_valid    <= 1'b0;
        end else begin
            shift_valid <= a_valid;
            if (a_valid) begin
                data_out       <= core_result;
                shift_overflow <= core_overflow;
            end
        end
    end

    // Counters watch the input strobe directly
    shift_op_counters u_cnt (
        .clk          (clk),
        .rst          (rst),
        .shift_enable (shift_enable),
        .shift_type   (shift_type),
        .left_count   (left_count),
        .right_count  (right_count),
        .rotate_count (rotate_count)
    );

    // Both pipeline valids clear on reset, so no stale pulse on release
    a_no_valid_after_reset: assert property (
        @(posedge clk) disable iff (rst)
        $past(rst) |-> !shift_valid
    ) else $error("shifter_top: shift_valid high right after reset");

endmodule

// ==== tb_shifter_checker.sv ====
// ====================
// Expects each result exactly two edges after its issue
// ====================
module tb_shifter_checker #(
    parameter int DATA_WIDTH = 32,
    parameter int NAME_BITS  = 128
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    shift_enable,
    input  logic [DATA_WIDTH-1:0]   data_out,
    input  logic                    shift_valid,
    input  logic                    shift_overflow,
    input  shifter_pkg::count_t     left_count,
    input  shifter_pkg::count_t     right_count,
    input  shifter_pkg::count_t     rotate_count,
    input  logic [NAME_BITS-1:0]    exp_name,
    input  logic [DATA_WIDTH-1:0]   exp_result,
    input  logic                    exp_overflow,
    input  shifter_pkg::count_t     exp_left,
    input  shifter_pkg::count_t     exp_right,
    input  shifter_pkg::count_t     exp_rotate,
    input  logic                    run_done,
    output logic                    drained,
    output logic                    report_done,
    output int                      pass_count,
    output int                      fail_count
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic [NAME_BITS-1:0]  name;
        logic [DATA_WIDTH-1:0] result;
        logic                  ovf;
        int                    issue_cycle;
    } pending_t;

    pending_t pending[$];
    int       cycle_count;
    logic     was_reset;

    initial begin
        pass_count  = 0;
        fail_count  = 0;
        drained     = 1'b1;
        report_done = 1'b0;
        cycle_count = 0;
        was_reset   = 1'b0;
    end

    task automatic compare_counter(input string what, input shifter_pkg::count_t expected,
                                   input shifter_pkg::count_t actual);
        if (expected !== actual) begin
            fail_count++;
            $display("mismatch %s: expected %0d, actual %0d", what, expected, actual);
        end else begin
            pass_count++;
            $display("ok %s: %0d", what, actual);
        end
    endtask

    always @(posedge clk) begin : watch
        pending_t entry;
        if (rst) begin
            was_reset = 1'b1;
        end else begin
            // First edge after release
            if (was_reset) begin
                was_reset = 1'b0;
                if (shift_valid) begin
                    fail_count++;
                    $display("shift_valid was high in the first cycle after reset");
                end else begin
                    pass_count++;
                    $display("ok reset_valid_low");
                end
            end
            if (shift_valid) begin
                if (pending.size() == 0) begin
                    fail_count++;
                    $display("shift_valid pulsed with no operation outstanding");
                end else begin
                    entry = pending.pop_front();
                    if (entry.result !== data_out || entry.ovf !== shift_overflow) begin
                        fail_count++;
                        $display("mismatch %s: expected 0x%h ovf %b, actual 0x%h ovf %b",
                                 entry.name, entry.result, entry.ovf, data_out, shift_overflow);
                    end else if (cycle_count - entry.issue_cycle != 2) begin
                        fail_count++;
                        $display("%s: result came %0d cycles after issue instead of 2",
                                 entry.name, cycle_count - entry.issue_cycle);
                    end else begin
                        pass_count++;
                        $display("ok %s: 0x%h ovf %b", entry.name, data_out, shift_overflow);
                    end
                end
            end
            if (shift_enable) begin
                entry.name        = exp_name;
                entry.result      = exp_result;
                entry.ovf         = exp_overflow;
                entry.issue_cycle = cycle_count;
                pending.push_back(entry);
            end
            drained <= (pending.size() == 0);
            if (run_done && !report_done) begin
                if (pending.size() != 0) begin
                    fail_count++;
                    $display("%0d operations never produced a result", pending.size());
                end
                compare_counter("left_count", exp_left, left_count);
                compare_counter("right_count", exp_right, right_count);
                compare_counter("rotate_count", exp_rotate, rotate_count);
                $display("tests passed %0d, failed %0d", pass_count, fail_count);
                report_done <= 1'b1;
            end
            cycle_count++;
        end
    end

endmodule

// ==== tb_shifter_top.sv ====
// ====================
// Drives the shifter from a table plus seeded random operations
// DATA_WIDTH fixed at 32 here
// ====================
module tb_shifter_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_WIDTH   = 32;
    localparam int AMT_WIDTH    = $clog2(DATA_WIDTH);
    localparam int NAME_BITS    = 128;
    localparam int RANDOM_OPS   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int MARGIN       = 50;

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [AMT_WIDTH-1:0]  amount_t;

    typedef struct {
        string                  name;
        word_t                  data;
        amount_t                amount;
        shifter_pkg::shift_op_t op;
        word_t                  result;
        logic                   ovf;
        int                     gap;
    } case_t;

    logic                   clk;
    logic                   rst;
    word_t                  data_in;
    amount_t                shift_amount;
    shifter_pkg::shift_op_t shift_type;
    logic                   shift_enable;
    word_t                  data_out;
    logic                   shift_valid;
    logic                   shift_overflow;
    shifter_pkg::count_t    left_count;
    shifter_pkg::count_t    right_count;
    shifter_pkg::count_t    rotate_count;

    // Expected values handed to the checker with each issue
    logic [NAME_BITS-1:0]   exp_name;
    word_t                  exp_result;
    logic                   exp_overflow;
    shifter_pkg::count_t    exp_left;
    shifter_pkg::count_t    exp_right;
    shifter_pkg::count_t    exp_rotate;
    logic                   run_done;
    logic                   drained;
    logic                   report_done;
    int                     pass_count;
    int                     fail_count;

    case_t cases[$];
    int    limit_cycles = 0;
    int    cycle_count;

    shifter_top #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .data_in        (data_in),
        .shift_amount   (shift_amount),
        .shift_type     (shift_type),
        .shift_enable   (shift_enable),
        .data_out       (data_out),
        .shift_valid    (shift_valid),
        .shift_overflow (shift_overflow),
        .left_count     (left_count),
        .right_count    (right_count),
        .rotate_count   (rotate_count)
    );

    tb_shifter_checker #(
        .DATA_WIDTH (DATA_WIDTH),
        .NAME_BITS  (NAME_BITS)
    ) u_chk (
        .clk            (clk),
        .rst            (rst),
        .shift_enable   (shift_enable),
        .data_out       (data_out),
        .shift_valid    (shift_valid),
        .shift_overflow (shift_overflow),
        .left_count     (left_count),
        .right_count    (right_count),
        .rotate_count   (rotate_count),
        .exp_name       (exp_name),
        .exp_result     (exp_result),
        .exp_overflow   (exp_overflow),
        .exp_left       (exp_left),
        .exp_right      (exp_right),
        .exp_rotate     (exp_rotate),
        .run_done       (run_done),
        .drained        (drained),
        .report_done    (report_done),
        .pass_count     (pass_count),
        .fail_count     (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected result from the operation rules, using double-width vectors
    function automatic void reference_shift(input word_t data, input amount_t amount,
                                            input shifter_pkg::shift_op_t op,
                                            output word_t result, output logic ovf);
        logic [2*DATA_WIDTH-1:0] wide;
        ovf = 1'b0;
        case (op)
            shifter_pkg::OP_LEFT: begin
                wide   = {{DATA_WIDTH{1'b0}}, data} << amount;
                result = wide[DATA_WIDTH-1:0];
                ovf    = |wide[2*DATA_WIDTH-1:DATA_WIDTH];
            end
            shifter_pkg::OP_RIGHT_LOGIC: result = data >> amount;
            shifter_pkg::OP_RIGHT_ARITH: result = $signed(data) >>> amount;
            default: begin
                wide   = {data, data} >> amount;
                result = wide[DATA_WIDTH-1:0];
            end
        endcase
    endfunction

    task automatic add_case(input string name, input word_t data, input amount_t amount,
                            input shifter_pkg::shift_op_t op, input word_t result,
                            input logic ovf, input int gap);
        case_t c;
        c.name   = name;
        c.data   = data;
        c.amount = amount;
        c.op     = op;
        c.result = result;
        c.ovf    = ovf;
        c.gap    = gap;
        cases.push_back(c);
    endtask

    task automatic build_cases();
        word_t                  data;
        amount_t                amount;
        shifter_pkg::shift_op_t op;
        word_t                  result;
        logic                   ovf;
        //       name           data          amt    op                           result  ovf gap
        add_case("left_one_31", 32'h00000001, 5'd31, shifter_pkg::OP_LEFT, 32'h80000000, 1'b0, 0);
        add_case("left_ovf_4",  32'hF0000001, 5'd4,  shifter_pkg::OP_LEFT, 32'h00000010, 1'b1, 0);
        add_case("left_zero",   32'hDEADBEEF, 5'd0,  shifter_pkg::OP_LEFT, 32'hDEADBEEF, 1'b0, 2);
        add_case("left_ovf_1",  32'h80000000, 5'd1,  shifter_pkg::OP_LEFT, 32'h00000000, 1'b1, 0);
        add_case("left_16",     32'h0000FFFF, 5'd16, shifter_pkg::OP_LEFT, 32'hFFFF0000, 1'b0, 1);
        add_case("srl_fill",    32'hF0000000, 5'd4, shifter_pkg::OP_RIGHT_LOGIC, 32'h0F000000,
                 1'b0, 0);
        add_case("srl_zero",    32'h12345678, 5'd0, shifter_pkg::OP_RIGHT_LOGIC, 32'h12345678,
                 1'b0, 0);
        add_case("sra_sign",    32'h80000000, 5'd31, shifter_pkg::OP_RIGHT_ARITH, 32'hFFFFFFFF,
                 1'b0, 1);
        add_case("sra_pos",     32'h7FFFFFFF, 5'd30, shifter_pkg::OP_RIGHT_ARITH, 32'h00000001,
                 1'b0, 0);
        add_case("rot_one",     32'h00000001, 5'd1,  shifter_pkg::OP_ROTATE, 32'h80000000, 1'b0, 0);
        add_case("rot_byte",    32'h12345678, 5'd8,  shifter_pkg::OP_ROTATE, 32'h78123456, 1'b0, 3);
        add_case("rot_31",      32'h80000001, 5'd31, shifter_pkg::OP_ROTATE, 32'h00000003, 1'b0, 0);
        for (int i = 0; i < RANDOM_OPS; i++) begin
            data   = $urandom;
            amount = amount_t'($urandom % DATA_WIDTH);
            op     = shifter_pkg::shift_op_t'($urandom % 4);
            reference_shift(data, amount, op, result, ovf);
            add_case($sformatf("rand_%0d", i), data, amount, op, result, ovf,
                     int'($urandom % 3));
        end
    endtask

    // One operation on the bus, then its idle gap
    task automatic apply_case(input case_t c);
        logic [NAME_BITS-1:0] name_bits;
        $sformat(name_bits, "%s", c.name);
        @(posedge clk);
        shift_enable <= 1'b1;
        data_in      <= c.data;
        shift_amount <= c.amount;
        shift_type   <= c.op;
        exp_name     <= name_bits;
        exp_result   <= c.result;
        exp_overflow <= c.ovf;
        case (c.op)
            shifter_pkg::OP_LEFT:   exp_left   <= exp_left + 1'b1;
            shifter_pkg::OP_ROTATE: exp_rotate <= exp_rotate + 1'b1;
            default:                exp_right  <= exp_right + 1'b1;
        endcase
        repeat (c.gap) begin
            @(posedge clk);
            shift_enable <= 1'b0;
        end
    endtask

    initial begin
        int gaps;
        void'($urandom(32'hc72a54f5));
        rst          = 1'b1;
        shift_enable = 1'b0;
        data_in      = '0;
        shift_amount = '0;
        shift_type   = shifter_pkg::OP_LEFT;
        exp_name     = '0;
        exp_result   = '0;
        exp_overflow = 1'b0;
        exp_left     = '0;
        exp_right    = '0;
        exp_rotate   = '0;
        run_done     = 1'b0;
        build_cases();
        gaps = 0;
        foreach (cases[i]) gaps += cases[i].gap;
        limit_cycles = cases.size() + gaps + MARGIN;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        foreach (cases[i]) apply_case(cases[i]);
        @(posedge clk);
        shift_enable <= 1'b0;
        // Up to two operations still in flight
        repeat (2) @(posedge clk);
        while (!drained) @(posedge clk);
        run_done <= 1'b1;
        while (!report_done) @(posedge clk);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog on the total run length
    initial begin
        cycle_count = 0;
        wait (limit_cycles != 0);
        while (cycle_count < limit_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
shifter_pkg.sv
barrel_shift_core.sv
shift_overflow_check.sv
shift_op_counters.sv
shifter_top.sv
tb_shifter_checker.sv
tb_shifter_top.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_shifter_top
FILELIST := verilog.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
